/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    // how the branch unit resolves an instruction
    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_always, br_jump_reg
    } br_kind_t;

    // opcode field positions
    localparam int op_31_26_hi = 31;
    localparam int op_31_26_lo = 26;
    localparam int op_25_22_hi = 25;
    localparam int op_25_22_lo = 22;
    localparam int op_21_20_hi = 21;
    localparam int op_21_20_lo = 20;
    localparam int op_19_15_hi = 19;
    localparam int op_19_15_lo = 15;

    // register and immediate fields
    localparam int rd_hi = 4;
    localparam int rd_lo = 0;
    localparam int rj_hi = 9;
    localparam int rj_lo = 5;
    localparam int rk_hi = 14;
    localparam int rk_lo = 10;
    localparam int i12_hi = 21;
    localparam int i12_lo = 10;
    localparam int i16_hi = 25;
    localparam int i16_lo = 10;
    localparam int i20_hi = 24;
    localparam int i20_lo = 5;
    // upper ten bits of offs26, the lower part shares the i16 field
    localparam int i26_top_hi = 9;
    localparam int i26_top_lo = 0;

    // group selectors
    localparam logic [5:0] opc_grp_alu = 6'h00;
    localparam logic [5:0] opc_grp_mem = 6'h0a;
    localparam logic [3:0] opc_sub_reg = 4'h0;
    localparam logic [3:0] opc_sub_shift = 4'h1;
    localparam logic [1:0] opc_reg_op2 = 2'h1;
    localparam logic [1:0] opc_shift_op2 = 2'h0;

    // op_19_15 inside the three-register group
    localparam logic [4:0] opc_add_w = 5'h00;
    localparam logic [4:0] opc_sub_w = 5'h02;
    localparam logic [4:0] opc_slt = 5'h04;
    localparam logic [4:0] opc_sltu = 5'h05;
    localparam logic [4:0] opc_nor = 5'h08;
    localparam logic [4:0] opc_and = 5'h09;
    localparam logic [4:0] opc_or = 5'h0a;
    localparam logic [4:0] opc_xor = 5'h0b;
    localparam logic [4:0] opc_sll_w = 5'h0e;
    localparam logic [4:0] opc_srl_w = 5'h0f;
    localparam logic [4:0] opc_sra_w = 5'h10;
    localparam logic [4:0] opc_slli_w = 5'h01;
    localparam logic [4:0] opc_srli_w = 5'h09;
    localparam logic [4:0] opc_srai_w = 5'h11;

    // op_25_22 for the 12-bit immediate and memory forms
    localparam logic [3:0] opc_slti = 4'h8;
    localparam logic [3:0] opc_sltui = 4'h9;
    localparam logic [3:0] opc_addi_w = 4'ha;
    localparam logic [3:0] opc_andi = 4'hd;
    localparam logic [3:0] opc_ori = 4'he;
    localparam logic [3:0] opc_xori = 4'hf;
    localparam logic [3:0] opc_ld_w = 4'h2;
    localparam logic [3:0] opc_st_w = 4'h6;

    // op_31_26 alone
    localparam logic [5:0] opc_lu12i_w = 6'h05;
    localparam logic [5:0] opc_pcaddu12i = 6'h07;
    localparam logic [5:0] opc_jirl = 6'h13;
    localparam logic [5:0] opc_b = 6'h14;
    localparam logic [5:0] opc_bl = 6'h15;
    localparam logic [5:0] opc_beq = 6'h16;
    localparam logic [5:0] opc_bne = 6'h17;
    localparam logic [5:0] opc_blt = 6'h18;
    localparam logic [5:0] opc_bge = 6'h19;
    localparam logic [5:0] opc_bltu = 6'h1a;
    localparam logic [5:0] opc_bgeu = 6'h1b;

endpackage

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int num_regs = 32;

    // reads as zero, never holds state
    localparam isa_pkg::reg_idx_t zero_reg = 5'd0;
    // return address of bl
    localparam isa_pkg::reg_idx_t link_reg = 5'd1;

    typedef logic [3:0] mem_mask_t;

endpackage

`default_nettype wire

/* logic/stage_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_ctrl (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 fd_valid,
    input  wire isa_pkg::word_t fd_pc,
    input  wire                 load_stall,
    input  wire                 e_allowin,
    output logic                d_allowin,
    output logic                de_valid,
    output isa_pkg::word_t      pc
);
    logic d_valid;
    logic ready_go;

    assign ready_go  = d_valid && !load_stall;
    assign de_valid  = ready_go;
    assign d_allowin = !d_valid || (ready_go && e_allowin);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_valid <= 1'b0;
        end else if (d_allowin) begin
            d_valid <= fd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fd_valid && d_allowin) begin
            pc <= fd_pc;
        end
    end

    // a newly valid output was either just accepted or held through a stall
    a_valid_source: assert property (@(posedge clk) disable iff (!rstn)
        $rose(de_valid) |-> $past(d_valid || (fd_valid && d_allowin)))
        else $error("de_valid rose with no instruction in decode");

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  wire isa_pkg::word_t  inst,
    output isa_pkg::alu_op_t     alu_op,
    output isa_pkg::reg_idx_t    rj,
    output isa_pkg::reg_idx_t    rk_or_rd,
    output logic                 uses_rj,
    output logic                 uses_rk_or_rd,
    output logic                 src1_is_pc,
    output logic                 src2_is_imm,
    output isa_pkg::word_t       imm,
    output logic                 gr_we,
    output pipe_pkg::mem_mask_t  mem_we,
    output isa_pkg::reg_idx_t    dest,
    output logic                 res_from_mem,
    output isa_pkg::br_kind_t    br_kind,
    output isa_pkg::word_t       br_offs
);
    import isa_pkg::*;
    import pipe_pkg::*;

    wire [5:0]  op6 = inst[op_31_26_hi:op_31_26_lo];
    wire [3:0]  op4 = inst[op_25_22_hi:op_25_22_lo];
    wire [1:0]  op2 = inst[op_21_20_hi:op_21_20_lo];
    wire [4:0]  op5 = inst[op_19_15_hi:op_19_15_lo];
    wire [4:0]  rd = inst[rd_hi:rd_lo];
    wire [4:0]  rk = inst[rk_hi:rk_lo];
    wire [11:0] i12 = inst[i12_hi:i12_lo];
    wire [15:0] i16 = inst[i16_hi:i16_lo];
    wire [19:0] i20 = inst[i20_hi:i20_lo];
    wire [25:0] i26 = {inst[i26_top_hi:i26_top_lo], i16};

    wire grp_reg   = op6 == opc_grp_alu && op4 == opc_sub_reg && op2 == opc_reg_op2;
    wire grp_shift = op6 == opc_grp_alu && op4 == opc_sub_shift && op2 == opc_shift_op2;
    wire grp_imm   = op6 == opc_grp_alu;
    wire grp_mem   = op6 == opc_grp_mem;
    // u12i forms need bit 25 clear
    wire u12i_ok   = !inst[op_25_22_hi];

    wire inst_add_w     = grp_reg && op5 == opc_add_w;
    wire inst_sub_w     = grp_reg && op5 == opc_sub_w;
    wire inst_slt       = grp_reg && op5 == opc_slt;
    wire inst_sltu      = grp_reg && op5 == opc_sltu;
    wire inst_nor       = grp_reg && op5 == opc_nor;
    wire inst_and       = grp_reg && op5 == opc_and;
    wire inst_or        = grp_reg && op5 == opc_or;
    wire inst_xor       = grp_reg && op5 == opc_xor;
    wire inst_sll_w     = grp_reg && op5 == opc_sll_w;
    wire inst_srl_w     = grp_reg && op5 == opc_srl_w;
    wire inst_sra_w     = grp_reg && op5 == opc_sra_w;
    wire inst_slli_w    = grp_shift && op5 == opc_slli_w;
    wire inst_srli_w    = grp_shift && op5 == opc_srli_w;
    wire inst_srai_w    = grp_shift && op5 == opc_srai_w;
    wire inst_slti      = grp_imm && op4 == opc_slti;
    wire inst_sltui     = grp_imm && op4 == opc_sltui;
    wire inst_addi_w    = grp_imm && op4 == opc_addi_w;
    wire inst_andi      = grp_imm && op4 == opc_andi;
    wire inst_ori       = grp_imm && op4 == opc_ori;
    wire inst_xori      = grp_imm && op4 == opc_xori;
    wire inst_ld_w      = grp_mem && op4 == opc_ld_w;
    wire inst_st_w      = grp_mem && op4 == opc_st_w;
    wire inst_lu12i_w   = op6 == opc_lu12i_w && u12i_ok;
    wire inst_pcaddu12i = op6 == opc_pcaddu12i && u12i_ok;
    wire inst_jirl      = op6 == opc_jirl;
    wire inst_b         = op6 == opc_b;
    wire inst_bl        = op6 == opc_bl;
    wire inst_beq       = op6 == opc_beq;
    wire inst_bne       = op6 == opc_bne;
    wire inst_blt       = op6 == opc_blt;
    wire inst_bge       = op6 == opc_bge;
    wire inst_bltu      = op6 == opc_bltu;
    wire inst_bgeu      = op6 == opc_bgeu;

    wire is_reg_alu   = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                        inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire is_shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_arith_imm = inst_addi_w | inst_slti | inst_sltui;
    wire is_logic_imm = inst_andi | inst_ori | inst_xori;
    wire is_upper     = inst_lu12i_w | inst_pcaddu12i;
    wire is_link      = inst_jirl | inst_bl;
    wire is_cmp_br    = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire writes_reg   = is_reg_alu | is_shift_imm | is_arith_imm | is_logic_imm |
                        is_upper | is_link | inst_ld_w;
    // address, link and pc-relative forms all add
    wire add_like     = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | is_link |
                        inst_pcaddu12i;
    wire [4:0] wr_reg = inst_bl ? link_reg : rd;

    assign alu_op = add_like                   ? alu_add  :
                    inst_sub_w                 ? alu_sub  :
                    (inst_slt | inst_slti)     ? alu_slt  :
                    (inst_sltu | inst_sltui)   ? alu_sltu :
                    (inst_and | inst_andi)     ? alu_and  :
                    inst_nor                   ? alu_nor  :
                    (inst_or | inst_ori)       ? alu_or   :
                    (inst_xor | inst_xori)     ? alu_xor  :
                    (inst_sll_w | inst_slli_w) ? alu_sll  :
                    (inst_srl_w | inst_srli_w) ? alu_srl  :
                    (inst_sra_w | inst_srai_w) ? alu_sra  :
                    inst_lu12i_w               ? alu_lui  : alu_none;

    assign rj            = inst[rj_hi:rj_lo];
    assign rk_or_rd      = (inst_st_w | is_cmp_br) ? rd : rk;
    assign uses_rj       = is_reg_alu | is_shift_imm | is_arith_imm | is_logic_imm |
                           inst_ld_w | inst_st_w | is_cmp_br | inst_jirl;
    assign uses_rk_or_rd = is_reg_alu | inst_st_w | is_cmp_br;
    assign src1_is_pc    = is_link | inst_pcaddu12i;
    assign src2_is_imm   = is_shift_imm | is_arith_imm | is_logic_imm | is_upper | is_link |
                           inst_ld_w | inst_st_w;

    assign imm = is_link      ? 32'd4 :
                 is_upper     ? {i20, 12'b0} :
                 is_logic_imm ? {20'b0, i12} : {{20{i12[11]}}, i12};

    // a write to r0 is dropped here so writeback never targets it
    assign gr_we        = writes_reg && wr_reg != zero_reg;
    assign dest         = gr_we ? wr_reg : zero_reg;
    assign mem_we       = inst_st_w ? '1 : '0;
    assign res_from_mem = inst_ld_w;

    assign br_kind = inst_beq  ? br_eq  :
                     inst_bne  ? br_ne  :
                     inst_blt  ? br_lt  :
                     inst_bge  ? br_ge  :
                     inst_bltu ? br_ltu :
                     inst_bgeu ? br_geu :
                     inst_jirl ? br_jump_reg :
                     (inst_b | inst_bl) ? br_always : br_none;

    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                          {{14{i16[15]}}, i16, 2'b0};

    always_comb begin
        assert (!(gr_we && mem_we != '0))
            else $error("decoder set both register write and memory write");
    end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire                    clk,
    input  wire isa_pkg::reg_idx_t raddr1,
    input  wire isa_pkg::reg_idx_t raddr2,
    input  wire                    we,
    input  wire isa_pkg::reg_idx_t waddr,
    input  wire isa_pkg::word_t    wdata,
    output isa_pkg::word_t         rdata1,
    output isa_pkg::word_t         rdata2
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (we && waddr != zero_reg) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == zero_reg) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == zero_reg) ? '0 : regs[raddr2];

    // decode clears gr_we for r0, so writeback never brings it here
    a_no_zero_write: assert property (@(posedge clk) we |-> waddr != zero_reg)
        else $error("writeback targets the zero register");

endmodule

`default_nettype wire

/* logic/operand_bypass.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
    input  wire isa_pkg::reg_idx_t rj,
    input  wire isa_pkg::reg_idx_t rk_or_rd,
    input  wire                    uses_rj,
    input  wire                    uses_rk_or_rd,
    input  wire isa_pkg::word_t    rf_rdata1,
    input  wire isa_pkg::word_t    rf_rdata2,
    input  wire isa_pkg::reg_idx_t e_dest,
    input  wire isa_pkg::word_t    e_wdata,
    input  wire                    e_is_load,
    input  wire isa_pkg::reg_idx_t m_dest,
    input  wire isa_pkg::word_t    m_wdata,
    input  wire                    w_we,
    input  wire isa_pkg::reg_idx_t w_addr,
    input  wire isa_pkg::word_t    w_wdata,
    output isa_pkg::word_t         rj_value,
    output isa_pkg::word_t         rkd_value,
    output logic                   load_stall
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // youngest producer wins
    function automatic word_t forward(input reg_idx_t idx, input word_t rf_value);
        if (idx == zero_reg) begin
            return '0;
        end else if (idx == e_dest) begin
            return e_wdata;
        end else if (idx == m_dest) begin
            return m_wdata;
        end else if (w_we && idx == w_addr) begin
            return w_wdata;
        end
        return rf_value;
    endfunction

    always_comb begin
        rj_value   = forward(rj, rf_rdata1);
        rkd_value  = forward(rk_or_rd, rf_rdata2);
        // load data only exists after the memory stage
        load_stall = e_is_load && e_dest != zero_reg &&
                     ((uses_rj && rj == e_dest) || (uses_rk_or_rd && rk_or_rd == e_dest));
    end

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  wire                    valid,
    input  wire isa_pkg::br_kind_t br_kind,
    input  wire isa_pkg::word_t    pc,
    input  wire isa_pkg::word_t    rj_value,
    input  wire isa_pkg::word_t    rkd_value,
    input  wire isa_pkg::word_t    br_offs,
    output logic                   br_taken,
    output isa_pkg::word_t         br_target
);
    import isa_pkg::*;

    logic [32:0] diff;
    logic        equal;
    logic        less;
    logic        less_u;
    logic        cond;

    // borrow out is the unsigned compare
    assign diff   = {1'b0, rj_value} - {1'b0, rkd_value};
    assign equal  = diff[31:0] == '0;
    assign less_u = diff[32];
    // with differing signs the negative operand is the smaller one
    assign less   = (rj_value[31] ^ rkd_value[31]) ? rj_value[31] : diff[31];

    always_comb begin
        case (br_kind)
            br_eq:       cond = equal;
            br_ne:       cond = !equal;
            br_lt:       cond = less;
            br_ge:       cond = !less;
            br_ltu:      cond = less_u;
            br_geu:      cond = !less_u;
            br_always,
            br_jump_reg: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    assign br_taken  = valid && cond;
    assign br_target = ((br_kind == br_jump_reg) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

/* logic/decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_top (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    fd_valid,
    input  wire isa_pkg::word_t    fd_pc,
    input  wire isa_pkg::word_t    inst_rdata,
    input  wire                    e_allowin,
    input  wire isa_pkg::reg_idx_t e_dest,
    input  wire isa_pkg::word_t    e_wdata,
    input  wire                    e_is_load,
    input  wire isa_pkg::reg_idx_t m_dest,
    input  wire isa_pkg::word_t    m_wdata,
    input  wire                    w_we,
    input  wire isa_pkg::reg_idx_t w_addr,
    input  wire isa_pkg::word_t    w_wdata,
    output logic                   d_allowin,
    output logic                   de_valid,
    output isa_pkg::word_t         de_pc,
    output isa_pkg::alu_op_t       de_alu_op,
    output isa_pkg::word_t         de_src1,
    output isa_pkg::word_t         de_src2,
    output isa_pkg::word_t         de_store_data,
    output logic                   de_gr_we,
    output pipe_pkg::mem_mask_t    de_mem_we,
    output isa_pkg::reg_idx_t      de_dest,
    output logic                   de_res_from_mem,
    output logic                   br_taken,
    output isa_pkg::word_t         br_target
);
    import isa_pkg::*;

    reg_idx_t rj;
    reg_idx_t rk_or_rd;
    logic     uses_rj;
    logic     uses_rk_or_rd;
    logic     src1_is_pc;
    logic     src2_is_imm;
    word_t    imm;
    br_kind_t br_kind;
    word_t    br_offs;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    rj_value;
    word_t    rkd_value;
    logic     load_stall;

    stage_ctrl u_stage_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .fd_valid   (fd_valid),
        .fd_pc      (fd_pc),
        .load_stall (load_stall),
        .e_allowin  (e_allowin),
        .d_allowin  (d_allowin),
        .de_valid   (de_valid),
        .pc         (de_pc)
    );

    inst_decoder u_inst_decoder (
        .inst          (inst_rdata),
        .alu_op        (de_alu_op),
        .rj            (rj),
        .rk_or_rd      (rk_or_rd),
        .uses_rj       (uses_rj),
        .uses_rk_or_rd (uses_rk_or_rd),
        .src1_is_pc    (src1_is_pc),
        .src2_is_imm   (src2_is_imm),
        .imm           (imm),
        .gr_we         (de_gr_we),
        .mem_we        (de_mem_we),
        .dest          (de_dest),
        .res_from_mem  (de_res_from_mem),
        .br_kind       (br_kind),
        .br_offs       (br_offs)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rk_or_rd),
        .we     (w_we),
        .waddr  (w_addr),
        .wdata  (w_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass u_operand_bypass (
        .rj            (rj),
        .rk_or_rd      (rk_or_rd),
        .uses_rj       (uses_rj),
        .uses_rk_or_rd (uses_rk_or_rd),
        .rf_rdata1     (rf_rdata1),
        .rf_rdata2     (rf_rdata2),
        .e_dest        (e_dest),
        .e_wdata       (e_wdata),
        .e_is_load     (e_is_load),
        .m_dest        (m_dest),
        .m_wdata       (m_wdata),
        .w_we          (w_we),
        .w_addr        (w_addr),
        .w_wdata       (w_wdata),
        .rj_value      (rj_value),
        .rkd_value     (rkd_value),
        .load_stall    (load_stall)
    );

    branch_unit u_branch_unit (
        .valid     (de_valid),
        .br_kind   (br_kind),
        .pc        (de_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    // alu operands
    assign de_src1       = src1_is_pc ? de_pc : rj_value;
    assign de_src2       = src2_is_imm ? imm : rkd_value;
    assign de_store_data = rkd_value;

endmodule

`default_nettype wire

/* tb/decode_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_tb;
    import isa_pkg::*;

    // 11 stimulus words then 10 expected words per vector
    localparam int num_vecs        = 31;
    localparam int vec_words       = 21;
    localparam int issue_limit     = 4;
    localparam int hold_cycles     = 3;
    localparam int watchdog_cycles = num_vecs * 8 + 20;

    logic     clk;
    logic     rstn;
    logic     fd_valid;
    word_t    fd_pc;
    word_t    inst_rdata;
    logic     e_allowin;
    reg_idx_t e_dest;
    word_t    e_wdata;
    logic     e_is_load;
    reg_idx_t m_dest;
    word_t    m_wdata;
    logic     w_we;
    reg_idx_t w_addr;
    word_t    w_wdata;

    logic                d_allowin;
    logic                de_valid;
    word_t               de_pc;
    alu_op_t             de_alu_op;
    word_t               de_src1;
    word_t               de_src2;
    word_t               de_store_data;
    logic                de_gr_we;
    pipe_pkg::mem_mask_t de_mem_we;
    reg_idx_t            de_dest;
    logic                de_res_from_mem;
    logic                br_taken;
    word_t               br_target;

    word_t vec_mem [num_vecs * vec_words];
    int    error_count;
    int    check_count;

    decode_top DUT (
        .clk             (clk),
        .rstn            (rstn),
        .fd_valid        (fd_valid),
        .fd_pc           (fd_pc),
        .inst_rdata      (inst_rdata),
        .e_allowin       (e_allowin),
        .e_dest          (e_dest),
        .e_wdata         (e_wdata),
        .e_is_load       (e_is_load),
        .m_dest          (m_dest),
        .m_wdata         (m_wdata),
        .w_we            (w_we),
        .w_addr          (w_addr),
        .w_wdata         (w_wdata),
        .d_allowin       (d_allowin),
        .de_valid        (de_valid),
        .de_pc           (de_pc),
        .de_alu_op       (de_alu_op),
        .de_src1         (de_src1),
        .de_src2         (de_src2),
        .de_store_data   (de_store_data),
        .de_gr_we        (de_gr_we),
        .de_mem_we       (de_mem_we),
        .de_dest         (de_dest),
        .de_res_from_mem (de_res_from_mem),
        .br_taken        (br_taken),
        .br_target       (br_target)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [175:0] output_bundle();
        return {de_pc, de_alu_op, de_src1, de_src2, de_store_data, de_gr_we, de_mem_we,
                de_dest, de_res_from_mem, br_taken, br_target};
    endfunction

    task automatic expect_word(input string name, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp)
        else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic apply_vector(input int base);
        fd_valid   <= 1'b1;
        fd_pc      <= vec_mem[base];
        inst_rdata <= vec_mem[base + 1];
        e_allowin  <= vec_mem[base + 2][0];
        e_dest     <= vec_mem[base + 3][4:0];
        e_wdata    <= vec_mem[base + 4];
        e_is_load  <= vec_mem[base + 5][0];
        m_dest     <= vec_mem[base + 6][4:0];
        m_wdata    <= vec_mem[base + 7];
        w_we       <= vec_mem[base + 8][0];
        w_addr     <= vec_mem[base + 9][4:0];
        w_wdata    <= vec_mem[base + 10];
    endtask

    task automatic release_load(input int idx);
        repeat (hold_cycles) begin
            @(posedge clk);
            check_count++;
            assert (!de_valid && !d_allowin)
            else begin
                $display("[FAIL] %0t: vector %0d issued under a load-use hazard", $time, idx);
                error_count++;
            end
        end
        // load result now sits in the memory stage
        m_dest    <= e_dest;
        m_wdata   <= e_wdata;
        e_dest    <= '0;
        e_wdata   <= '0;
        e_is_load <= 1'b0;
    endtask

    task automatic hold_under_backpressure(input int idx);
        logic [175:0] held;
        @(posedge clk);
        held = output_bundle();
        repeat (hold_cycles) begin
            @(posedge clk);
            check_count++;
            assert (de_valid && !d_allowin && output_bundle() === held)
            else begin
                $display("[FAIL] %0t: vector %0d outputs moved under back-pressure",
                         $time, idx);
                error_count++;
            end
        end
        e_allowin <= 1'b1;
    endtask

    task automatic wait_issue(input int idx, output logic seen);
        seen = 1'b0;
        for (int c = 0; c < issue_limit && !seen; c++) begin
            @(posedge clk);
            seen = de_valid && e_allowin;
        end
        assert (seen)
        else begin
            $display("vector %0d was accepted but de_valid never rose", idx);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input int base);
        word_t flags;
        flags = vec_mem[base + 15];
        expect_word("pc", de_pc, vec_mem[base]);
        expect_word("alu_op", 32'(de_alu_op), vec_mem[base + 12]);
        expect_word("src1", de_src1, vec_mem[base + 13]);
        expect_word("src2", de_src2, vec_mem[base + 14]);
        expect_word("gr_we", 32'(de_gr_we), 32'(flags[0]));
        expect_word("res_from_mem", 32'(de_res_from_mem), 32'(flags[1]));
        expect_word("dest", 32'(de_dest), vec_mem[base + 16]);
        expect_word("mem_we", 32'(de_mem_we), vec_mem[base + 17]);
        expect_word("br_taken", 32'(br_taken), vec_mem[base + 18]);
        // target only matters when taken
        if (vec_mem[base + 18][0]) begin
            expect_word("br_target", br_target, vec_mem[base + 19]);
        end
        if (vec_mem[base + 17] != '0) begin
            expect_word("store_data", de_store_data, vec_mem[base + 20]);
        end
    endtask

    task automatic run_vector(input int idx);
        int   base;
        logic seen;
        base = idx * vec_words;
        @(posedge clk);
        apply_vector(base);
        // stage is empty, so this edge takes the instruction
        @(posedge clk);
        fd_valid <= 1'b0;
        if (vec_mem[base + 11][0]) begin
            release_load(idx);
        end else if (!vec_mem[base + 2][0]) begin
            hold_under_backpressure(idx);
        end
        wait_issue(idx, seen);
        if (seen) begin
            compare_outputs(base);
        end
    endtask

    initial begin
        rstn        = 1'b0;
        fd_valid    = 1'b0;
        fd_pc       = '0;
        inst_rdata  = '0;
        e_allowin   = 1'b1;
        e_dest      = '0;
        e_wdata     = '0;
        e_is_load   = 1'b0;
        m_dest      = '0;
        m_wdata     = '0;
        w_we        = 1'b0;
        w_addr      = '0;
        w_wdata     = '0;
        error_count = 0;
        check_count = 0;
        $readmemh("tb/decode_testdata.txt", vec_mem);
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int v = 0; v < num_vecs; v++) begin
            run_vector(v);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/decode_testdata.txt */
// in: pc inst e_allowin e_dest e_wdata e_is_load m_dest m_wdata w_we w_addr w_wdata
// out: stall alu_op src1 src2 {res_from_mem,gr_we} dest mem_we br_taken br_target sdata
1c000000 00101483 1 4 11 0 5 22 0 0 0  0 1 11 22 1 3 0 0 0 0
1c000004 00111486 1 5 44 0 0 0 1 4 33  0 2 33 44 1 6 0 0 0 0
1c000008 00129407 1 0 0 0 5 55 0 0 0  0 4 0 55 1 7 0 0 0 0
1c00000c 00182928 1 9 80000000 0 a 3 0 0 0  0 b 80000000 3 1 8 0 0 0 0
1c000010 00408c62 1 3 7 0 0 0 0 0 0  0 9 7 23 1 2 0 0 0 0
1c000014 02bffdac 1 0 0 0 d 100 0 0 0  0 1 100 ffffffff 1 c 0 0 0 0
1c000018 0360000e 1 0 0 0 0 0 0 0 0  0 5 0 800 1 e 0 0 0 0
1c00001c 142468af 1 5 5a 0 0 0 0 0 0  0 c 5a 12345000 1 f 0 0 0 0
1c000020 1c000030 1 0 0 0 0 0 0 0 0  0 1 1c000020 1000 1 10 0 0 0 0
1c000024 fc000000 1 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
1c000028 00100083 1 4 a1 0 4 b2 1 4 c3  0 1 a1 0 1 3 0 0 0 0
1c00002c 00100083 1 0 0 0 4 b2 1 4 c3  0 1 b2 0 1 3 0 0 0 0
1c000030 00150089 1 4 d4 1 0 0 0 0 0  1 7 d4 0 1 9 0 0 0 0
1c000034 0015948a 0 4 f0 0 5 f 0 0 0  0 8 f0 f 1 a 0 0 0 0
1c000038 58004085 1 4 7 0 5 7 0 0 0  0 0 7 7 0 0 0 1 1c000078 0
1c00003c 58004085 1 4 7 0 5 8 0 0 0  0 0 7 8 0 0 0 0 0 0
1c000040 5c004085 1 4 7 0 5 8 0 0 0  0 0 7 8 0 0 0 1 1c000080 0
1c000044 5c004085 1 4 7 0 5 7 0 0 0  0 0 7 7 0 0 0 0 0 0
1c000048 63ffc085 1 4 ffffffff 0 5 1 0 0 0  0 0 ffffffff 1 0 0 0 1 1c000008 0
1c00004c 60004085 1 4 1 0 5 ffffffff 0 0 0  0 0 1 ffffffff 0 0 0 0 0 0
1c000050 64004085 1 4 5 0 5 5 0 0 0  0 0 5 5 0 0 0 1 1c000090 0
1c000054 64004085 1 4 ffffffff 0 5 0 0 0 0  0 0 ffffffff 0 0 0 0 0 0 0
1c000058 68004085 1 4 1 0 5 ffffffff 0 0 0  0 0 1 ffffffff 0 0 0 1 1c000098 0
1c00005c 68004085 1 4 ffffffff 0 5 1 0 0 0  0 0 ffffffff 1 0 0 0 0 0 0
1c000060 6c004085 1 4 ffffffff 0 5 1 0 0 0  0 0 ffffffff 1 0 0 0 1 1c0000a0 0
1c000064 6c004085 1 4 0 0 5 1 0 0 0  0 0 0 1 0 0 0 0 0 0
1c000068 50008000 1 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 1 1c0000e8 0
1c00006c 54008000 1 0 0 0 0 0 0 0 0  0 1 1c00006c 4 1 1 0 1 1c0000ec 0
1c000070 4c000881 1 4 1c001000 0 0 0 0 0 0  0 1 1c000070 4 1 1 0 1 1c001008 0
1c000074 29802085 1 4 1000 0 0 0 1 5 77  0 1 1000 8 0 0 f 0 0 77
1c000078 28bff086 1 0 0 0 4 2000 0 0 0  0 1 2000 fffffffc 3 6 0 0 0 0

/* decode.f */
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_ctrl.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_top.sv
tb/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f decode.f
./obj_dir/Vdecode_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
